// ==== mod_defines.svh ====
`ifndef MOD_DEFINES_SVH
`define MOD_DEFINES_SVH

// frame geometry.
`define MOD_DEPTH 249

// modulation sample addressing.
`define MOD_IDX_W 15
`define MOD_SEG_SIZE 32768

// timer clock divider width.
`define MOD_DIV_W 16

// memory read latency, request register to sample.
`define MOD_RD_LAT 2

// operand, product and output register stages.
`define MOD_MULT_LAT 3

// strobe to first output word.
`define MOD_OUT_LAT 6

`endif

// ==== mod_pkg.sv ====
`include "mod_defines.svh"

package mod_pkg;

  typedef struct packed {
    logic [`MOD_DIV_W-1:0] div;    // cycles per index step.
    logic [`MOD_IDX_W-1:0] cycle;  // last index before wrap.
  } mod_seg_cfg_t;

  typedef struct packed {
    logic               segment;
    logic               stop;
    mod_seg_cfg_t [1:0] seg;
  } mod_cfg_t;

  typedef struct packed {
    logic [`MOD_IDX_W-1:0] idx_0;
    logic [`MOD_IDX_W-1:0] idx_1;
    logic                  segment;
    logic                  stop;
  } mod_cnt_t;

  typedef struct packed {
    logic                  segment;
    logic [`MOD_IDX_W-1:0] idx;
  } mod_rd_t;

  typedef struct packed {
    logic                  segment;
    logic [`MOD_IDX_W-1:0] idx;
    logic [7:0]            value;
  } mod_wr_t;

  typedef struct packed {
    logic [7:0] intensity;
    logic [7:0] phase;
  } drive_in_t;

  typedef struct packed {
    logic [15:0] intensity;  // intensity times modulation sample.
    logic [7:0]  phase;
  } drive_out_t;

endpackage

// ==== delay_fifo.sv ====
module delay_fifo #(
  parameter type T     = logic [7:0],
  parameter int  DEPTH = 1
) (
  input  logic CLK,
  input  T     din,
  output T     dout
);

  T stages [DEPTH];

  always_ff @(posedge CLK) begin
    stages[0] <= din;
    for (int i = 1; i < DEPTH; i++) begin
      stages[i] <= stages[i-1];
    end
  end

  assign dout = stages[DEPTH-1];

endmodule

// ==== mod_timer.sv ====
`include "mod_defines.svh"

module mod_timer (
  input  logic               CLK,
  input  logic               reset,
  input  logic               cfg_valid,
  input  mod_pkg::mod_cfg_t  cfg,
  output mod_pkg::mod_cnt_t  cnt
);

  import mod_pkg::*;

  mod_cfg_t                         cfg_q;
  logic [1:0][`MOD_DIV_W-1:0]       div_cnt;
  logic [1:0][`MOD_IDX_W-1:0]       idx;

  // per-segment divider and index counters.
  always_ff @(posedge CLK) begin
    if (reset) begin
      cfg_q   <= '0;
      div_cnt <= '0;
      idx     <= '0;
    end else if (cfg_valid) begin
      cfg_q   <= cfg;
      div_cnt <= '0;  // a new config restarts both segments.
      idx     <= '0;
    end else begin
      for (int i = 0; i < 2; i++) begin
        if (div_cnt[i] == cfg_q.seg[i].div - 1'b1) begin
          div_cnt[i] <= '0;
          if (idx[i] == cfg_q.seg[i].cycle) begin
            idx[i] <= '0;
          end else begin
            idx[i] <= idx[i] + 1'b1;
          end
        end else begin
          div_cnt[i] <= div_cnt[i] + 1'b1;
        end
      end
    end
  end

  // count word lags the counters by one cycle.
  always_ff @(posedge CLK) begin
    if (reset) begin
      cnt <= '0;
    end else begin
      cnt.idx_0   <= idx[0];
      cnt.idx_1   <= idx[1];
      cnt.segment <= cfg_q.segment;
      cnt.stop    <= cfg_q.stop;  // counting goes on while stopped.
    end
  end

  a_idx_in_cycle: assert property (
    @(posedge CLK) disable iff (reset)
      (idx[0] <= cfg_q.seg[0].cycle) && (idx[1] <= cfg_q.seg[1].cycle)
  ) else $error("modulation index beyond its cycle length");

endmodule

// ==== mod_memory.sv ====
`include "mod_defines.svh"

module mod_memory (
  input  logic              CLK,
  input  logic              wr_valid,
  input  mod_pkg::mod_wr_t  wr,
  input  mod_pkg::mod_rd_t  rd,
  output logic [7:0]        value
);

  import mod_pkg::*;

  logic [7:0] bank_0 [`MOD_SEG_SIZE];
  logic [7:0] bank_1 [`MOD_SEG_SIZE];

  mod_rd_t    rd_q;
  logic       seg_q;
  logic [7:0] data_0;
  logic [7:0] data_1;

  always_ff @(posedge CLK) begin
    if (wr_valid && !wr.segment) begin
      bank_0[wr.idx] <= wr.value;
    end
  end

  always_ff @(posedge CLK) begin
    if (wr_valid && wr.segment) begin
      bank_1[wr.idx] <= wr.value;
    end
  end

  // address stage, then data stage.
  always_ff @(posedge CLK) begin
    rd_q   <= rd;
    data_0 <= bank_0[rd_q.idx];
    data_1 <= bank_1[rd_q.idx];
    seg_q  <= rd_q.segment;
  end

  assign value = seg_q ? data_1 : data_0;  // bank select after the registers.

endmodule

// ==== modulation_multiplier.sv ====
`include "mod_defines.svh"

module modulation_multiplier (
  input  logic                 CLK,
  input  logic                 reset,
  input  logic                 din_valid,
  input  mod_pkg::drive_in_t   din,
  input  mod_pkg::mod_cnt_t    mod_cnt,
  output mod_pkg::mod_rd_t     mod_rd,
  input  logic [7:0]           mod_value,
  output logic                 dout_valid,
  output mod_pkg::drive_out_t  dout
);

  // run cycles spent before dout_valid rises.
  localparam int lead_cycles = `MOD_OUT_LAT - `MOD_RD_LAT - 2;
  localparam int cnt_w       = $clog2(`MOD_DEPTH + lead_cycles + 1);

  typedef enum logic [2:0] {
    waiting,
    wait_load_0,
    wait_load_1,
    mod_load,  // never entered.
    run
  } state_t;

  state_t                        state;
  logic [cnt_w-1:0]              run_cnt;
  logic [cnt_w-1:0]              out_cnt;
  logic [`MOD_IDX_W-1:0]         idx_0_q;
  logic [`MOD_IDX_W-1:0]         idx_1_q;
  logic [7:0]                    intensity_d;
  logic [7:0]                    phase_d;
  logic [7:0]                    mult_a;
  logic [7:0]                    mult_b;
  logic [`MOD_MULT_LAT-2:0][15:0] prod_q;

  // indices lag one cycle to line up with segment and stop.
  always_ff @(posedge CLK) begin
    idx_0_q <= mod_cnt.idx_0;
    idx_1_q <= mod_cnt.idx_1;
  end

  always_ff @(posedge CLK) begin
    if (reset) begin
      state      <= waiting;
      dout_valid <= 1'b0;
      run_cnt    <= '0;
      out_cnt    <= '0;
      mod_rd     <= '0;
    end else begin
      case (state)
        waiting: begin
          dout_valid <= 1'b0;
          if (din_valid) begin
            run_cnt <= '0;
            out_cnt <= '0;
            if (!mod_cnt.stop) begin
              mod_rd.idx     <= mod_cnt.segment ? idx_1_q : idx_0_q;
              mod_rd.segment <= mod_cnt.segment;
            end
            state <= wait_load_0;
          end
        end
        wait_load_0: begin
          state <= wait_load_1;
        end
        wait_load_1: begin
          state <= run;
        end
        run: begin
          run_cnt <= run_cnt + 1'b1;
          if (run_cnt >= cnt_w'(lead_cycles)) begin
            dout_valid <= 1'b1;
            out_cnt    <= out_cnt + 1'b1;
            if (out_cnt == cnt_w'(`MOD_DEPTH - 1)) begin
              state <= waiting;
            end
          end
        end
        default: begin
          state <= waiting;
        end
      endcase
    end
  end

  delay_fifo #(
    .T     (logic [7:0]),
    .DEPTH (`MOD_RD_LAT + 1)
  ) intensity_delay (
    .CLK  (CLK),
    .din  (din.intensity),
    .dout (intensity_d)
  );

  delay_fifo #(
    .T     (logic [7:0]),
    .DEPTH (`MOD_OUT_LAT)
  ) phase_delay (
    .CLK  (CLK),
    .din  (din.phase),
    .dout (phase_d)
  );

  // unsigned 8x8 multiply.
  always_ff @(posedge CLK) begin
    mult_a    <= intensity_d;
    mult_b    <= mod_value;
    prod_q[0] <= mult_a * mult_b;
    for (int i = 1; i < `MOD_MULT_LAT - 1; i++) begin
      prod_q[i] <= prod_q[i-1];
    end
  end

  assign dout.intensity = prod_q[`MOD_MULT_LAT-2];
  assign dout.phase     = phase_d;

  a_strobe_when_idle: assert property (
    @(posedge CLK) disable iff (reset)
      din_valid |-> state == waiting
  ) else $error("frame strobe outside the waiting state");

  a_out_latency: assert property (
    @(posedge CLK) disable iff (reset)
      din_valid |-> ##(`MOD_OUT_LAT) dout_valid
  ) else $error("first output word missed its slot");

endmodule

// ==== modulation_top.sv ====
module modulation_top (
  input  logic                 CLK,
  input  logic                 reset,
  input  logic                 cfg_valid,
  input  mod_pkg::mod_cfg_t    cfg,
  input  logic                 wr_valid,
  input  mod_pkg::mod_wr_t     wr,
  input  logic                 din_valid,
  input  mod_pkg::drive_in_t   din,
  output logic                 dout_valid,
  output mod_pkg::drive_out_t  dout
);

  import mod_pkg::*;

  mod_cnt_t   mod_cnt;
  mod_rd_t    mod_rd;
  logic [7:0] mod_value;

  mod_timer timer0 (
    .CLK       (CLK),
    .reset     (reset),
    .cfg_valid (cfg_valid),
    .cfg       (cfg),
    .cnt       (mod_cnt)
  );

  mod_memory memory0 (
    .CLK      (CLK),
    .wr_valid (wr_valid),
    .wr       (wr),
    .rd       (mod_rd),
    .value    (mod_value)
  );

  modulation_multiplier mult0 (
    .CLK        (CLK),
    .reset      (reset),
    .din_valid  (din_valid),
    .din        (din),
    .mod_cnt    (mod_cnt),
    .mod_rd     (mod_rd),
    .mod_value  (mod_value),
    .dout_valid (dout_valid),
    .dout       (dout)
  );

endmodule

// ==== tb_modulation.sv ====
`include "mod_defines.svh"

module tb_modulation;

  import mod_pkg::*;

  localparam int clk_period   = 20;
  localparam int frames_seg_0 = 6;
  localparam int frames_seg_1 = 5;
  localparam int frames_stop  = 4;
  localparam int frames_again = 4;
  localparam int num_frames   = frames_seg_0 + frames_seg_1 + frames_stop + frames_again;
  localparam int setup_cycles = 2 * `MOD_SEG_SIZE + 64;
  localparam int limit_cycles = setup_cycles + num_frames * (`MOD_DEPTH + 20) + 200;

  typedef struct packed {
    int         due;  // model cycle whose edge puts the word on dout.
    drive_out_t word;
  } expect_t;

  logic       CLK;
  logic       reset;
  logic       cfg_valid;
  mod_cfg_t   cfg;
  logic       wr_valid;
  mod_wr_t    wr;
  logic       din_valid;
  drive_in_t  din;
  logic       dout_valid;
  drive_out_t dout;

  logic [31:0] lcg_state   = 32'h2c69;
  int          error_count = 0;

  // reference model state.
  logic [7:0]                 mem_0 [`MOD_SEG_SIZE];
  logic [7:0]                 mem_1 [`MOD_SEG_SIZE];
  mod_cfg_t                   tmr_cfg;
  logic [1:0][`MOD_DIV_W-1:0] tmr_div;
  logic [1:0][`MOD_IDX_W-1:0] tmr_idx;
  logic [1:0][`MOD_IDX_W-1:0] cnt_idx;
  logic [1:0][`MOD_IDX_W-1:0] lag_idx;
  logic                       cnt_seg;
  logic                       cnt_stop;
  logic                       rd_seg;
  logic [`MOD_IDX_W-1:0]      rd_idx;
  logic [7:0]                 sample;
  int                         word_cnt = `MOD_DEPTH;  // no frame in flight.
  int                         cyc      = 0;
  expect_t                    exp_q [$];
  int                         exp_head = 0;
  int                         out_words = 0;  // words seen with dout_valid high.

  modulation_top dut0 (
    .CLK        (CLK),
    .reset      (reset),
    .cfg_valid  (cfg_valid),
    .cfg        (cfg),
    .wr_valid   (wr_valid),
    .wr         (wr),
    .din_valid  (din_valid),
    .din        (din),
    .dout_valid (dout_valid),
    .dout       (dout)
  );

  initial begin
    CLK = 1'b0;
    forever #(clk_period / 2) CLK = ~CLK;
  end

  function automatic logic [15:0] next_random();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state[31:16];
  endfunction

  function automatic int rand_below(int n);
    return int'(next_random()) % n;
  endfunction

  task automatic fail_and_stop();
    $display("*** FAILED ***");
    $fatal(1, "stopping at the first error");
  endtask

  task automatic flag_mismatch(string name, logic [31:0] actual, logic [31:0] expected);
    error_count++;
    $display("Error at time %0t: %s is %0h, expected %0h", $time, name, actual, expected);
    fail_and_stop();
  endtask

  task automatic abort_run(string what);
    error_count++;
    $display("Run aborted at time %0t: %s", $time, what);
    fail_and_stop();
  endtask

  task automatic fill_memory();
    logic [15:0] r;
    for (int s = 0; s < 2; s++) begin
      for (int a = 0; a < `MOD_SEG_SIZE; a++) begin
        r = next_random();
        @(posedge CLK);
        wr_valid   <= 1'b1;
        wr.segment <= s[0];
        wr.idx     <= `MOD_IDX_W'(a);
        wr.value   <= r[7:0];
      end
    end
    @(posedge CLK);
    wr_valid <= 1'b0;
  endtask

  task automatic load_config(logic segment, logic stop);
    mod_cfg_t c;
    c.segment = segment;
    c.stop    = stop;
    for (int i = 0; i < 2; i++) begin
      c.seg[i].div   = `MOD_DIV_W'(1 + rand_below(4));
      c.seg[i].cycle = `MOD_IDX_W'(3 + rand_below(12));
    end
    @(posedge CLK);
    cfg_valid <= 1'b1;
    cfg       <= c;
    @(posedge CLK);
    cfg_valid <= 1'b0;
  endtask

  task automatic send_frame();
    logic [15:0] r;
    for (int k = 0; k < `MOD_DEPTH; k++) begin
      r = next_random();
      @(posedge CLK);
      din_valid     <= (k == 0);
      din.intensity <= r[15:8];
      din.phase     <= r[7:0];
    end
    r = next_random();
    @(posedge CLK);
    din_valid <= 1'b0;
    din       <= r;  // idle filler.
  endtask

  task automatic wait_output_done();
    @(negedge CLK);
    while (!dout_valid) @(negedge CLK);
    while (dout_valid) @(negedge CLK);
  endtask

  task automatic run_frames(int n);
    int gap;
    for (int f = 0; f < n; f++) begin
      gap = (f % 3 == 1) ? 0 : rand_below(8);
      repeat (gap) @(posedge CLK);
      send_frame();
      wait_output_done();
    end
  endtask

  always @(posedge CLK) begin : model
    drive_out_t w;
    expect_t    e;
    cyc++;
    if (reset) begin
      tmr_cfg  = '0;
      tmr_div  = '0;
      tmr_idx  = '0;
      cnt_idx  = '0;
      lag_idx  = '0;
      cnt_seg  = 1'b0;
      cnt_stop = 1'b0;
      rd_seg   = 1'b0;
      rd_idx   = '0;
      word_cnt = `MOD_DEPTH;
    end else begin
      // segment and stop come from the count word, the index one cycle older.
      if (din_valid) begin
        if (!cnt_stop) begin
          rd_seg = cnt_seg;
          rd_idx = cnt_seg ? lag_idx[1] : lag_idx[0];
        end
        sample   = rd_seg ? mem_1[rd_idx] : mem_0[rd_idx];
        word_cnt = 0;
      end
      if (word_cnt < `MOD_DEPTH) begin
        w.intensity = 16'(sample) * 16'(din.intensity);
        w.phase     = din.phase;
        e.due       = cyc + `MOD_OUT_LAT - 1;
        e.word      = w;
        exp_q.push_back(e);
        word_cnt++;
      end
      if (wr_valid) begin
        if (wr.segment) begin
          mem_1[wr.idx] = wr.value;
        end else begin
          mem_0[wr.idx] = wr.value;
        end
      end
      lag_idx  = cnt_idx;
      cnt_idx  = tmr_idx;  // count word is registered.
      cnt_seg  = tmr_cfg.segment;
      cnt_stop = tmr_cfg.stop;
      if (cfg_valid) begin
        tmr_cfg = cfg;
        tmr_div = '0;
        tmr_idx = '0;
      end else begin
        for (int i = 0; i < 2; i++) begin
          if (tmr_div[i] == tmr_cfg.seg[i].div - 16'd1) begin
            tmr_div[i] = '0;
            if (tmr_idx[i] == tmr_cfg.seg[i].cycle) begin
              tmr_idx[i] = '0;
            end else begin
              tmr_idx[i] = tmr_idx[i] + 1'b1;
            end
          end else begin
            tmr_div[i] = tmr_div[i] + 16'd1;
          end
        end
      end
    end
  end

  always @(negedge CLK) begin : output_check
    expect_t e;
    if (cyc > 0) begin
      if (dout_valid === 1'b1) begin
        out_words++;
      end
      if (exp_head < exp_q.size() && exp_q[exp_head].due == cyc) begin
        e = exp_q[exp_head];
        exp_head++;
        assert (dout_valid === 1'b1)
          else flag_mismatch("dout_valid", 32'(dout_valid), 32'd1);
        assert (dout.intensity === e.word.intensity)
          else flag_mismatch("dout.intensity", 32'(dout.intensity), 32'(e.word.intensity));
        assert (dout.phase === e.word.phase)
          else flag_mismatch("dout.phase", 32'(dout.phase), 32'(e.word.phase));
      end else begin
        assert (dout_valid === 1'b0)
          else flag_mismatch("dout_valid", 32'(dout_valid), 32'd0);
      end
    end
  end

  initial begin : watchdog
    #(limit_cycles * clk_period);
    abort_run("watchdog expired before the test sequence finished");
  end

  initial begin : stimulus
    reset     = 1'b1;
    cfg_valid = 1'b0;
    cfg       = '0;
    wr_valid  = 1'b0;
    wr        = '0;
    din_valid = 1'b0;
    din       = '0;
    repeat (3) @(posedge CLK);
    reset <= 1'b0;
    fill_memory();
    load_config(1'b0, 1'b0);
    run_frames(frames_seg_0);
    load_config(1'b1, 1'b0);  // segment 1 samples and counting.
    run_frames(frames_seg_1);
    load_config(1'b1, 1'b1);  // sample held while the timer runs on.
    run_frames(frames_stop);
    load_config(1'b0, 1'b0);
    run_frames(frames_again);
    repeat (8) @(negedge CLK);
    if (out_words != num_frames * `MOD_DEPTH) begin
      abort_run("the number of output words differs from the words sent");
    end
    if (error_count == 0) begin
      $display("*** PASSED ***");
      $finish;
    end else begin
      fail_and_stop();
    end
  end

endmodule

// ==== tb.f ====
+incdir+.
mod_pkg.sv
delay_fifo.sv
mod_timer.sv
mod_memory.sv
modulation_multiplier.sv
modulation_top.sv
tb_modulation.sv

// ==== run.sh ====
#!/bin/sh
# Compile and run the modulation testbench with Verilator.

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_modulation -f tb.f; then
  echo "compile failed"
  exit 1
fi

./obj_dir/Vtb_modulation > sim.log 2>&1
status=$?
cat sim.log

if grep -q '\*\*\* FAILED \*\*\*' sim.log; then
  echo "simulation failed"
  exit 1
fi

if [ "$status" -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

echo "simulation passed"
exit 0
